/* verilog/riscv_config.svh */
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// datapath and address width
`define RISCV_XLEN 32

`define RISCV_REG_COUNT 32
`define RISCV_REG_ADDR_W 5

// first fetch after reset
`define RISCV_RESET_PC 0
`define RISCV_INSTR_STEP 4

`endif

/* verilog/riscv_pkg.sv */
`include "riscv_config.svh"

package riscv_pkg;

  typedef logic [`RISCV_XLEN-1:0] word_t;
  typedef logic [`RISCV_REG_ADDR_W-1:0] reg_addr_t;

  // decoded instruction class
  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_alu,
    op_load,
    op_store,
    op_system,
    op_illegal
  } opcode_t;

  // arithmetic ops first, then branch compares
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_instr,
    st_execute,
    st_finish_load,
    st_finish_store,
    st_check_pc,
    st_reg_write,
    st_trap
  } cpu_state_t;

endpackage

/* verilog/riscv_decoder.sv */
module riscv_decoder import riscv_pkg::*; (
  input  word_t     instr,
  output opcode_t   opcode,
  output alu_op_t   alu_op,
  output reg_addr_t rd,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output word_t     immediate,
  output logic      instr_valid
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t shamt;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // sign-extended immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign shamt = {27'b0, instr[24:20]};

  always_comb begin
    opcode = op_illegal;
    alu_op = alu_add;
    immediate = imm_i;
    case (instr[6:0])
      7'b0110111: begin
        opcode = op_lui;
        immediate = imm_u;
      end
      7'b0010111: begin
        opcode = op_auipc;
        immediate = imm_u;
      end
      7'b1101111: begin
        opcode = op_jal;
        immediate = imm_j;
      end
      7'b1100111: begin
        if (funct3 == 3'b000) begin
          opcode = op_jalr;
        end
      end
      7'b1100011: begin
        immediate = imm_b;
        opcode = op_branch;
        case (funct3)
          3'b000: alu_op = alu_eq;
          3'b001: alu_op = alu_ne;
          3'b100: alu_op = alu_lt;
          3'b101: alu_op = alu_ge;
          3'b110: alu_op = alu_ltu;
          3'b111: alu_op = alu_geu;
          default: opcode = op_illegal;
        endcase
      end
      // word access only
      7'b0000011: begin
        if (funct3 == 3'b010) begin
          opcode = op_load;
        end
      end
      7'b0100011: begin
        immediate = imm_s;
        if (funct3 == 3'b010) begin
          opcode = op_store;
        end
      end
      7'b0010011, 7'b0110011: begin
        opcode = op_alu;
        case (funct3)
          3'b000: alu_op = (instr[5] && funct7[5]) ? alu_sub : alu_add;
          3'b001: alu_op = alu_sll;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        if (!instr[5] && (funct3 == 3'b001 || funct3 == 3'b101)) begin
          immediate = shamt;
        end
        // funct7 matters for register forms and immediate shifts
        if ((instr[5] || funct3 == 3'b001 || funct3 == 3'b101) &&
            funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b101 || (instr[5] && funct3 == 3'b000)))) begin
          opcode = op_illegal;
        end
      end
      7'b1110011: begin
        if (instr == 32'h0000_0073 || instr == 32'h0010_0073) begin
          opcode = op_system;
        end
      end
      default: opcode = op_illegal;
    endcase
  end

  assign instr_valid = (opcode != op_illegal);

endmodule

/* verilog/riscv_alu.sv */
module riscv_alu import riscv_pkg::*; (
  input  word_t   alu_a,
  input  word_t   alu_b,
  input  alu_op_t alu_op,
  output word_t   alu_result,
  output logic    branch_taken
);

  logic [4:0] shamt;

  assign shamt = alu_b[4:0];

  always_comb begin
    alu_result = '0;
    case (alu_op)
      alu_add:  alu_result = alu_a + alu_b;
      alu_sub:  alu_result = alu_a - alu_b;
      alu_xor:  alu_result = alu_a ^ alu_b;
      alu_or:   alu_result = alu_a | alu_b;
      alu_and:  alu_result = alu_a & alu_b;
      alu_sll:  alu_result = alu_a << shamt;
      alu_srl:  alu_result = alu_a >> shamt;
      alu_sra:  alu_result = word_t'($signed(alu_a) >>> shamt);
      alu_slt:  alu_result = word_t'($signed(alu_a) < $signed(alu_b));
      alu_sltu: alu_result = word_t'(alu_a < alu_b);
      default:  alu_result = '0;
    endcase
  end

  // compares only, arithmetic ops never branch
  always_comb begin
    case (alu_op)
      alu_eq:  branch_taken = (alu_a == alu_b);
      alu_ne:  branch_taken = (alu_a != alu_b);
      alu_lt:  branch_taken = ($signed(alu_a) < $signed(alu_b));
      alu_ge:  branch_taken = ($signed(alu_a) >= $signed(alu_b));
      alu_ltu: branch_taken = (alu_a < alu_b);
      alu_geu: branch_taken = (alu_a >= alu_b);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

/* verilog/riscv_regfile.sv */
`include "riscv_config.svh"

module riscv_regfile import riscv_pkg::*; (
  input  logic      clk,
  input  logic      reg_we,
  input  reg_addr_t reg_waddr,
  input  word_t     reg_wdata,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`RISCV_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reg_we && reg_waddr != '0) begin
      regs[reg_waddr] <= reg_wdata;
    end
  end

  // x0 slot is never written, so force zero on read
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* verilog/riscv_control.sv */
`include "riscv_config.svh"

module riscv_control import riscv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  output logic      mem_valid,
  output logic      mem_instr,
  input  logic      mem_ready,
  output word_t     mem_addr,
  output word_t     mem_wdata,
  output logic [3:0] mem_wstrb,
  input  word_t     mem_rdata,
  output logic      trap,
  output word_t     instr,
  input  opcode_t   opcode,
  input  alu_op_t   alu_op,
  input  reg_addr_t rd,
  input  word_t     immediate,
  input  logic      instr_valid,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output word_t     alu_a,
  output word_t     alu_b,
  output alu_op_t   alu_op_sel,
  input  word_t     alu_result,
  input  logic      branch_taken,
  output logic      reg_we,
  output reg_addr_t reg_waddr,
  output word_t     reg_wdata
);

  cpu_state_t state;
  word_t pc;
  word_t next_pc;
  word_t wb_data;
  word_t pc_step;
  word_t branch_target;
  logic reg_form;

  // bit 5 separates register from immediate ALU forms
  assign reg_form = instr[5];
  assign pc_step = pc + word_t'(`RISCV_INSTR_STEP);
  assign branch_target = branch_taken ? pc + immediate : pc_step;

  // auipc and jal add to pc, everything else works from rs1
  always_comb begin
    alu_a = rs1_data;
    alu_b = immediate;
    alu_op_sel = alu_add;
    case (opcode)
      op_auipc, op_jal: alu_a = pc;
      op_alu: begin
        alu_b = reg_form ? rs2_data : immediate;
        alu_op_sel = alu_op;
      end
      op_branch: begin
        alu_b = rs2_data;
        alu_op_sel = alu_op;
      end
      default: alu_op_sel = alu_add;
    endcase
  end

  // rd stays valid since instr is held until the next fetch
  assign reg_we = (state == st_reg_write);
  assign reg_waddr = rd;
  assign reg_wdata = wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= word_t'(`RISCV_RESET_PC);
      next_pc <= word_t'(`RISCV_RESET_PC);
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= 4'b0000;
      trap <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= 4'b0000;
          mem_addr <= next_pc;
          pc <= next_pc;
          state <= st_wait_instr;
        end
        st_wait_instr: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            instr <= mem_rdata;
            state <= st_execute;
          end
        end
        st_execute: begin
          next_pc <= pc_step;
          wb_data <= alu_result;
          if (!instr_valid) begin
            state <= st_trap;
          end else begin
            case (opcode)
              op_alu, op_auipc: state <= st_reg_write;
              op_lui: begin
                wb_data <= immediate;
                state <= st_reg_write;
              end
              // raw jalr sum, so an odd target traps in st_check_pc
              op_jal, op_jalr: begin
                next_pc <= alu_result;
                wb_data <= pc_step;
                state <= st_check_pc;
              end
              op_branch: begin
                next_pc <= branch_target;
                state <= st_check_pc;
              end
              op_load, op_store: begin
                if (alu_result[1:0] != 2'b00) begin
                  state <= st_trap;
                end else begin
                  mem_valid <= 1'b1;
                  mem_instr <= 1'b0;
                  mem_addr <= alu_result;
                  mem_wdata <= rs2_data;
                  mem_wstrb <= (opcode == op_store) ? 4'b1111 : 4'b0000;
                  state <= (opcode == op_store) ? st_finish_store : st_finish_load;
                end
              end
              default: state <= st_trap;
            endcase
          end
        end
        st_finish_load: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            wb_data <= mem_rdata;
            state <= st_reg_write;
          end
        end
        st_finish_store: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= st_fetch;
          end
        end
        st_check_pc: begin
          if (next_pc[1:0] != 2'b00) begin
            state <= st_trap;
          end else begin
            state <= (opcode == op_branch) ? st_fetch : st_reg_write;
          end
        end
        st_reg_write: state <= st_fetch;
        st_trap: trap <= 1'b1;
        default: state <= st_trap;
      endcase
    end
  end

endmodule

/* verilog/riscv.sv */
module riscv import riscv_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output logic       mem_valid,
  output logic       mem_instr,
  input  logic       mem_ready,
  output word_t      mem_addr,
  output word_t      mem_wdata,
  output logic [3:0] mem_wstrb,
  input  word_t      mem_rdata,
  output logic       trap
);

  word_t instr;
  opcode_t opcode;
  alu_op_t alu_op;
  alu_op_t alu_op_sel;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t immediate;
  logic instr_valid;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  logic branch_taken;
  logic reg_we;
  reg_addr_t reg_waddr;
  word_t reg_wdata;

  riscv_control control_inst (.*);

  riscv_decoder decoder_inst (.*);

  riscv_alu alu_inst (
    .alu_a(alu_a),
    .alu_b(alu_b),
    .alu_op(alu_op_sel),
    .alu_result(alu_result),
    .branch_taken(branch_taken)
  );

  riscv_regfile regfile_inst (.*);

endmodule

/* testbench/riscv_tb.sv */
module riscv_tb import riscv_pkg::*; ();

  typedef enum logic [2:0] {k_alu_r, k_alu_i, k_branch, k_jal, k_jalr, k_ldst, k_trap} kind_t;
  // op is {alt, funct3} for alu rows, funct3 for branches, trap variant for trap rows
  typedef struct packed {
    kind_t kind;
    logic [3:0] op;
    word_t a;
    word_t b;
    logic rnd;
  } row_t;

  localparam int num_rows = 38;
  localparam word_t ebreak_instr = 32'h0010_0073;
  // programs stay below the data words at 0x80 and 0x100
  localparam word_t data_base = 32'h80;
  localparam row_t rows [num_rows] = '{
    '{k_alu_r, 4'h0, 0, 0, 1}, '{k_alu_r, 4'h8, 0, 0, 1}, '{k_alu_r, 4'h4, 0, 0, 1},
    '{k_alu_r, 4'h6, 0, 0, 1}, '{k_alu_r, 4'h7, 0, 0, 1}, '{k_alu_r, 4'h1, 0, 0, 1},
    '{k_alu_r, 4'h5, 0, 0, 1}, '{k_alu_r, 4'hd, 0, 0, 1}, '{k_alu_r, 4'h2, 0, 0, 1},
    '{k_alu_r, 4'h3, 0, 0, 1},
    '{k_alu_i, 4'h0, 0, 0, 1}, '{k_alu_i, 4'h4, 0, 0, 1}, '{k_alu_i, 4'h6, 0, 0, 1},
    '{k_alu_i, 4'h7, 0, 0, 1}, '{k_alu_i, 4'h1, 0, 0, 1}, '{k_alu_i, 4'h5, 0, 0, 1},
    '{k_alu_i, 4'hd, 0, 0, 1}, '{k_alu_i, 4'h2, 0, 0, 1}, '{k_alu_i, 4'h3, 0, 0, 1},
    '{k_branch, 4'h0, 5, 5, 0}, '{k_branch, 4'h0, 5, 6, 0},
    '{k_branch, 4'h1, 5, 6, 0}, '{k_branch, 4'h1, 7, 7, 0},
    '{k_branch, 4'h4, 32'hffff_ffff, 1, 0}, '{k_branch, 4'h4, 1, 32'hffff_ffff, 0},
    '{k_branch, 4'h5, 1, 32'hffff_ffff, 0}, '{k_branch, 4'h5, 32'hffff_ffff, 1, 0},
    '{k_branch, 4'h6, 1, 32'hffff_ffff, 0}, '{k_branch, 4'h6, 32'hffff_ffff, 1, 0},
    '{k_branch, 4'h7, 32'hffff_ffff, 1, 0}, '{k_branch, 4'h7, 1, 32'hffff_ffff, 0},
    '{k_jal, 4'h0, 0, 0, 0}, '{k_jalr, 4'h0, 0, 0, 0}, '{k_ldst, 4'h0, 0, 0, 1},
    '{k_trap, 4'h0, 0, 0, 0}, '{k_trap, 4'h1, 0, 0, 0},
    '{k_trap, 4'h2, 0, 0, 0}, '{k_trap, 4'h3, 0, 0, 0}
  };

  logic clk = 1'b0;
  logic reset;
  logic mem_valid;
  logic mem_instr;
  logic mem_ready = 1'b0;
  word_t mem_addr;
  word_t mem_wdata;
  logic [3:0] mem_wstrb;
  word_t mem_rdata = '0;
  logic trap;

  word_t image [256];
  word_t mem [256];
  int delay_tab [1024];
  logic [15:0] lfsr = 16'd50317;
  int emit_idx;
  word_t expected;
  int errors = 0;
  logic stored;
  word_t store_value;
  logic [3:0] store_strobe;
  logic pending = 1'b0;
  int delay_left = 0;
  logic [9:0] req_count = '0;

  riscv riscv_inst (.*);

  always #4 clk = ~clk;

  // memory model with the image copied in while reset is high
  always @(posedge clk) begin
    if (reset) begin
      mem <= image;
      mem_ready <= 1'b0;
      stored <= 1'b0;
      pending = 1'b0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
      check_fetch(mem_instr, mem_addr < data_base, mem_addr);
      if (mem_wstrb != 4'b0000) begin
        mem[mem_addr[9:2]] <= mem_wdata;
        if (mem_addr == 32'h100) begin
          stored <= 1'b1;
          store_value <= mem_wdata;
          store_strobe <= mem_wstrb;
        end
      end
    end else if (mem_valid) begin
      if (!pending) begin
        pending = 1'b1;
        delay_left = delay_tab[req_count];
        req_count = req_count + 10'd1;
      end
      if (delay_left == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[9:2]];
        pending = 1'b0;
      end else begin
        delay_left = delay_left - 1;
      end
    end
  end

  // galois lfsr stepped once per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic word_t alu_rule(input logic [3:0] op, input word_t a, input word_t b);
    case (op[2:0])
      3'd0: return op[3] ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return op[3] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  task automatic emit(input word_t w);
    image[emit_idx] = w;
    emit_idx = emit_idx + 1;
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic load_const(input reg_addr_t rd, input word_t v);
    word_t up;
    up = v + 32'h800;
    emit({up[31:12], rd, 7'h37});
    emit(enc_i(v[11:0], rd, 3'b000, rd, 7'h13));
  endtask

  task automatic build_program(input row_t r, input word_t a, input word_t b);
    word_t b_eff;
    for (int j = 0; j < 256; j++) begin
      image[j] = 32'h5a5a_0000 ^ word_t'(j * 4);
    end
    emit_idx = 0;
    case (r.kind)
      k_alu_r: begin
        load_const(1, a);
        load_const(2, b);
        emit({r.op[3] ? 7'h20 : 7'h00, 5'd2, 5'd1, r.op[2:0], 5'd3, 7'h33});
        expected = alu_rule(r.op, a, b);
      end
      k_alu_i: begin
        load_const(1, a);
        if (r.op[1:0] == 2'b01) begin
          b_eff = {27'b0, b[4:0]};
          emit(enc_i({r.op[3] ? 7'h20 : 7'h00, b[4:0]}, 1, r.op[2:0], 3, 7'h13));
        end else begin
          b_eff = {{20{b[11]}}, b[11:0]};
          emit(enc_i(b[11:0], 1, r.op[2:0], 3, 7'h13));
        end
        expected = alu_rule(r.op, a, b_eff);
      end
      k_branch: begin
        load_const(1, a);
        load_const(2, b);
        // branch forward 12 bytes to the store of 2
        emit({1'b0, 6'd0, 5'd2, 5'd1, r.op[2:0], 4'd6, 1'b0, 7'h63});
        emit(enc_i(12'd1, 0, 3'b000, 3, 7'h13));
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd0, 7'h6f});
        emit(enc_i(12'd2, 0, 3'b000, 3, 7'h13));
        expected = branch_rule(r.op[2:0], a, b) ? 32'd2 : 32'd1;
      end
      k_jal: begin
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd3, 7'h6f});
        emit(ebreak_instr);
        expected = 32'd4;
      end
      k_jalr: begin
        emit(enc_i(12'd16, 0, 3'b000, 6, 7'h13));
        emit(enc_i(12'd0, 6, 3'b000, 3, 7'h67));
        emit(ebreak_instr);
        emit(ebreak_instr);
        expected = 32'd8;
      end
      k_ldst: begin
        load_const(1, a);
        emit(enc_s(12'h080, 1, 0));
        emit(enc_i(12'h080, 0, 3'b010, 2, 7'h03));
        emit({b[31:12], 5'd3, 7'h37});
        // auipc sits at byte address 20
        emit({20'd0, 5'd4, 7'h17});
        emit({7'h00, 5'd3, 5'd2, 3'b000, 5'd3, 7'h33});
        emit({7'h00, 5'd4, 5'd3, 3'b000, 5'd3, 7'h33});
        expected = a + {b[31:12], 12'b0} + 32'd20;
      end
      default: begin
        case (r.op)
          4'h0: emit(enc_i(12'h102, 0, 3'b010, 3, 7'h03));
          4'h1: emit(enc_s(12'h101, 0, 0));
          4'h2: emit(32'hffff_ffff);
          default: begin
            emit(enc_i(12'd17, 0, 3'b000, 6, 7'h13));
            emit(enc_i(12'd0, 6, 3'b000, 3, 7'h67));
            // fall-through or a target of 16 both reach a store
            emit(enc_s(12'h100, 3, 0));
            emit(ebreak_instr);
          end
        endcase
        expected = '0;
      end
    endcase
    emit(enc_s(12'h100, 3, 0));
    emit(ebreak_instr);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_trap(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %0t: trap flag got %b expected %b", $time, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_fetch(input logic got, input logic exp, input word_t addr);
    if (got !== exp) begin
      $display("ERROR %0t: fetch flag at %h got %b expected %b", $time, addr, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_state(input logic ok, input string what);
    if (!ok) begin
      $display("%s", what);
      errors = errors + 1;
    end
  endtask

  initial begin
    row_t r;
    word_t a;
    word_t b;
    int errors_before;
    int passed;
    reset = 1'b1;
    passed = 0;
    for (int j = 0; j < 1024; j++) begin
      delay_tab[j] = int'(rand_bits(2) % 3);
    end
    for (int i = 0; i < num_rows; i++) begin
      r = rows[i];
      a = r.rnd ? rand_bits(32) : r.a;
      b = r.rnd ? rand_bits(32) : r.b;
      errors_before = errors;
      build_program(r, a, b);
      @(posedge clk);
      reset <= 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      while (!trap) @(negedge clk);
      repeat (3) @(negedge clk);
      check_trap(trap, 1'b1);
      if (r.kind == k_trap) begin
        check_state(!stored, $sformatf("test %0d stored to 0x100 although it should trap", i));
        check_state(!mem_valid, $sformatf("test %0d left mem_valid high after the trap", i));
      end else begin
        check_state(stored, $sformatf("test %0d trapped before storing its result", i));
        if (stored) begin
          check_word(store_value, expected, $sformatf("test %0d stored word", i));
          check_word({28'b0, store_strobe}, 32'hf, $sformatf("test %0d write strobes", i));
        end
      end
      if (errors == errors_before) begin
        passed = passed + 1;
      end
      $display("test %0d %s op %h: %s", i, r.kind.name(), r.op,
               (errors == errors_before) ? "ok" : "failed");
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_rows, passed, num_rows - passed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog sized to 400 cycles per row
  initial begin
    #(num_rows * 400 * 8);
    $display("timeout, the core never finished all tests");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* riscv.f */
+incdir+verilog
verilog/riscv_pkg.sv
verilog/riscv_decoder.sv
verilog/riscv_alu.sv
verilog/riscv_regfile.sv
verilog/riscv_control.sv
verilog/riscv.sv
testbench/riscv_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the riscv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f riscv.f --top-module riscv_tb -o riscv_sim

./obj_dir/riscv_sim > sim.log
cat sim.log

# the run passes only if the testbench printed its pass line
grep -q "^RESULT: PASS$" sim.log
